// File: source/msx_cart_params.svh
`ifndef MSX_CART_PARAMS_SVH
`define MSX_CART_PARAMS_SVH

// ----------------------------------------------------------
// cartridge memory map
// ----------------------------------------------------------

// ram address width, 1 KiB
// page register holds the bits above the low address byte
`define CART_RAM_ADDR_BITS 10

// adr[15:14] value of the paged window, 0x4000 to 0x7fff
`define CART_MEM_WINDOW 2'b01

// first claimed i/o port, base+0 to base+2 belong to us
`define CART_IO_BASE 8'h40

// constant returned by the id port
`define CART_ID_VALUE 8'hA5

`endif

// File: source/msx_cart_pkg.sv
`default_nettype none

package msx_cart_pkg;

	// ----------------------------------------------------------
	// access destination
	// ----------------------------------------------------------

	// none is still acknowledged, just without read data
	typedef enum logic [1:0] {
		TARGET_NONE = 2'd0,
		TARGET_RAM  = 2'd1,
		TARGET_REG  = 2'd2
	} target_e;

	// ----------------------------------------------------------
	// i/o register select
	// ----------------------------------------------------------

	// encoding equals port offset from the i/o base
	typedef enum logic [1:0] {
		REG_PAGE    = 2'd0,
		REG_SCRATCH = 2'd1,
		REG_ID      = 2'd2
	} reg_sel_e;

endpackage

`default_nettype wire

// File: source/msx_bus_bridge.sv
`default_nettype none

module msx_bus_bridge (
	input  wire logic        clk,
	input  wire logic        n_reset,
	// slot side, all asynchronous
	input  wire logic [15:0] adr,
	input  wire logic [7:0]  i_data,
	output logic      [7:0]  o_data,
	output logic             is_output,
	input  wire logic        n_sltsl,
	input  wire logic        n_rd,
	input  wire logic        n_wr,
	input  wire logic        n_ioreq,
	// internal request side
	output logic      [15:0] bus_address,
	input  wire logic [7:0]  bus_read_data,
	input  wire logic        bus_read_data_en,
	output logic      [7:0]  bus_write_data,
	output logic             bus_io_req,
	output logic             bus_memory_req,
	input  wire logic        bus_ack,
	output logic             bus_write
);

	logic        ff_n_rd;
	logic        ff_n_wr;
	logic        strobe_fall;
	logic        io_start;
	logic        mem_start;
	logic        ff_io_req;
	logic        ff_memory_req;
	logic        ff_access_hold;
	logic [15:0] ff_bus_address;
	logic [7:0]  ff_bus_write_data;
	logic [7:0]  ff_bus_read_data;
	logic        ff_bus_read_data_en;

	// ----------------------------------------------------------
	// strobe sampling
	// ----------------------------------------------------------

	// previous strobe levels, idle high
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_n_rd <= 1'b1;
			ff_n_wr <= 1'b1;
		end else begin
			ff_n_rd <= n_rd;
			ff_n_wr <= n_wr;
		end
	end

	// falling edge of either strobe, seen at the first sampling edge
	assign strobe_fall = (ff_n_rd & ~n_rd) | (ff_n_wr & ~n_wr);

	// i/o wins over memory, the z80 never drives both
	assign io_start  = strobe_fall & ~n_ioreq & ~ff_access_hold;
	assign mem_start = strobe_fall & ~n_sltsl & n_ioreq & ~ff_access_hold;

	// ----------------------------------------------------------
	// request generation
	// ----------------------------------------------------------

	// request holds until the ack is seen at a clock edge
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_io_req     <= 1'b0;
			ff_memory_req <= 1'b0;
		end else if (bus_ack) begin
			ff_io_req     <= 1'b0;
			ff_memory_req <= 1'b0;
		end else begin
			if (io_start) begin
				ff_io_req <= 1'b1;
			end
			if (mem_start) begin
				ff_memory_req <= 1'b1;
			end
		end
	end

	// one access per strobe, released once both strobes are back high
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_access_hold <= 1'b0;
		end else if (io_start || mem_start) begin
			ff_access_hold <= 1'b1;
		end else if (ff_n_rd && ff_n_wr) begin
			ff_access_hold <= 1'b0;
		end
	end

	// ----------------------------------------------------------
	// address and data latches
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_bus_address <= 16'd0;
		end else if (io_start || mem_start) begin
			ff_bus_address <= adr;
		end
	end

	// write data taken at the same moment as the address
	always_ff @(posedge clk) begin
		if (io_start || mem_start) begin
			ff_bus_write_data <= i_data;
		end
	end

	// read data kept while n_rd stays low, dropped when it rises
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_bus_read_data    <= 8'd0;
			ff_bus_read_data_en <= 1'b0;
		end else if (ff_n_rd) begin
			ff_bus_read_data    <= 8'd0;
			ff_bus_read_data_en <= 1'b0;
		end else if (bus_read_data_en) begin
			ff_bus_read_data    <= bus_read_data;
			ff_bus_read_data_en <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// outputs
	// ----------------------------------------------------------

	assign bus_address    = ff_bus_address;
	assign bus_write_data = ff_bus_write_data;
	assign bus_io_req     = ff_io_req;
	assign bus_memory_req = ff_memory_req;
	assign bus_write      = ~ff_n_wr;

	// buffer enable falls straight away with n_rd
	assign o_data    = ff_bus_read_data;
	assign is_output = ff_bus_read_data_en & ~n_rd;

	// only one request kind may be pending at any time
	assert property (@(posedge clk) disable iff (!n_reset)
		!(ff_io_req && ff_memory_req));

endmodule

`default_nettype wire

// File: source/access_decoder.sv
`default_nettype none

`include "msx_cart_params.svh"

module access_decoder (
	input  wire logic                  clk,
	input  wire logic                  n_reset,
	input  wire logic [15:0]           bus_address,
	input  wire logic                  bus_io_req,
	input  wire logic                  bus_memory_req,
	input  wire logic                  bus_write,
	output logic                       access_start,
	output msx_cart_pkg::target_e      target,
	output msx_cart_pkg::reg_sel_e     reg_sel,
	output logic                       ram_we,
	output logic                       reg_we
);

	import msx_cart_pkg::*;

	logic     req_any;
	logic     req_d;
	logic     mem_hit;
	logic     io_hit;
	logic [7:0] port_off;
	target_e  target_next;

	// ----------------------------------------------------------
	// classification
	// ----------------------------------------------------------

	assign req_any  = bus_io_req | bus_memory_req;
	assign port_off = bus_address[7:0] - `CART_IO_BASE;

	// memory window on the top two address bits
	assign mem_hit = bus_memory_req && (bus_address[15:14] == `CART_MEM_WINDOW);
	// three ports from the base, wraps below base give large offsets
	assign io_hit  = bus_io_req && (port_off < 8'd3);

	always_comb begin
		if (mem_hit) begin
			target_next = TARGET_RAM;
		end else if (io_hit) begin
			target_next = TARGET_REG;
		end else begin
			target_next = TARGET_NONE;
		end
	end

	// ----------------------------------------------------------
	// start pulse, one cycle after the request rises
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			req_d        <= 1'b0;
			access_start <= 1'b0;
			target       <= TARGET_NONE;
			reg_sel      <= REG_PAGE;
		end else begin
			req_d        <= req_any;
			access_start <= req_any & ~req_d;
			target       <= target_next;
			reg_sel      <= reg_sel_e'(port_off[1:0]);
		end
	end

	// write enables only during the start cycle
	assign ram_we = access_start && bus_write && (target == TARGET_RAM);
	assign reg_we = access_start && bus_write && (target == TARGET_REG);

	// the request must still be pending while its access starts
	assert property (@(posedge clk) disable iff (!n_reset)
		access_start |-> req_any);

endmodule

`default_nettype wire

// File: source/cart_ram.sv
`default_nettype none

`include "msx_cart_params.svh"

module cart_ram (
	input  wire logic                          clk,
	input  wire logic [7:0]                    offset,
	input  wire logic [`CART_RAM_ADDR_BITS-9:0] page,
	input  wire logic                          we,
	input  wire logic [7:0]                    wdata,
	output logic      [7:0]                    rdata
);

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------

	logic [7:0] mem [0:(1 << `CART_RAM_ADDR_BITS)-1];
	logic [`CART_RAM_ADDR_BITS-1:0] addr;

	// page selects the 256 byte bank, offset the byte
	assign addr = {page, offset};

	// ----------------------------------------------------------
	// single port, write plus registered read
	// ----------------------------------------------------------

	// read runs every cycle, data lands one cycle after the address
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: source/io_register_bank.sv
`default_nettype none

`include "msx_cart_params.svh"

module io_register_bank (
	input  wire logic                          clk,
	input  wire logic                          n_reset,
	input  wire msx_cart_pkg::reg_sel_e        reg_sel,
	input  wire logic                          we,
	input  wire logic [7:0]                    wdata,
	output logic      [7:0]                    rdata,
	output logic      [`CART_RAM_ADDR_BITS-9:0] page
);

	import msx_cart_pkg::*;

	logic [`CART_RAM_ADDR_BITS-9:0] ff_page;
	logic [7:0]                     ff_scratch;

	// ----------------------------------------------------------
	// register writes
	// ----------------------------------------------------------

	// page keeps only its low bits, id port has nothing to write
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_page    <= '0;
			ff_scratch <= 8'd0;
		end else if (we) begin
			case (reg_sel)
				REG_PAGE:    ff_page    <= wdata[`CART_RAM_ADDR_BITS-9:0];
				REG_SCRATCH: ff_scratch <= wdata;
				default:     ;
			endcase
		end
	end

	// ----------------------------------------------------------
	// registered read
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		case (reg_sel)
			REG_PAGE:    rdata <= {{(16 - `CART_RAM_ADDR_BITS){1'b0}}, ff_page};
			REG_SCRATCH: rdata <= ff_scratch;
			REG_ID:      rdata <= `CART_ID_VALUE;
			default:     rdata <= 8'd0;
		endcase
	end

	// upper ram address bits
	assign page = ff_page;

endmodule

`default_nettype wire

// File: source/response_mux.sv
`default_nettype none

module response_mux (
	input  wire logic                  clk,
	input  wire logic                  n_reset,
	input  wire logic                  access_start,
	input  wire msx_cart_pkg::target_e target,
	input  wire logic                  bus_write,
	input  wire logic [7:0]            ram_rdata,
	input  wire logic [7:0]            reg_rdata,
	output logic                       bus_ack,
	output logic      [7:0]            bus_read_data,
	output logic                       bus_read_data_en
);

	import msx_cart_pkg::*;

	target_e ff_target;
	logic    ff_read;
	logic    ff_ack;

	// ----------------------------------------------------------
	// ack stage
	// ----------------------------------------------------------

	// the execute blocks answer one cycle after the start
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_ack    <= 1'b0;
			ff_target <= TARGET_NONE;
			ff_read   <= 1'b0;
		end else begin
			ff_ack <= access_start;
			if (access_start) begin
				ff_target <= target;
				ff_read   <= ~bus_write;
			end
		end
	end

	// ----------------------------------------------------------
	// data select
	// ----------------------------------------------------------

	always_comb begin
		case (ff_target)
			TARGET_RAM: bus_read_data = ram_rdata;
			TARGET_REG: bus_read_data = reg_rdata;
			default:    bus_read_data = 8'd0;
		endcase
	end

	assign bus_ack = ff_ack;

	// unclaimed reads get the ack but leave the slot bus floating
	assign bus_read_data_en = ff_ack && ff_read && (ff_target != TARGET_NONE);

	// each start gives a single ack cycle
	assert property (@(posedge clk) disable iff (!n_reset)
		bus_ack |=> !bus_ack);

endmodule

`default_nettype wire

// File: source/msx_cart_top.sv
`default_nettype none

`include "msx_cart_params.svh"

module msx_cart_top (
	input  wire logic        clk,
	input  wire logic        n_reset,
	input  wire logic [15:0] adr,
	input  wire logic [7:0]  i_data,
	output logic      [7:0]  o_data,
	output logic             is_output,
	input  wire logic        n_sltsl,
	input  wire logic        n_rd,
	input  wire logic        n_wr,
	input  wire logic        n_ioreq
);

	import msx_cart_pkg::*;

	// ----------------------------------------------------------
	// internal nets
	// ----------------------------------------------------------

	logic [15:0] bus_address;
	logic [7:0]  bus_write_data;
	logic        bus_io_req;
	logic        bus_memory_req;
	logic        bus_write;
	logic        bus_ack;
	logic [7:0]  bus_read_data;
	logic        bus_read_data_en;

	logic        access_start;
	target_e     target;
	reg_sel_e    reg_sel;
	logic        ram_we;
	logic        reg_we;
	logic [7:0]  ram_rdata;
	logic [7:0]  reg_rdata;
	logic [`CART_RAM_ADDR_BITS-9:0] page;

	// ----------------------------------------------------------
	// slot bridge and decode
	// ----------------------------------------------------------

	msx_bus_bridge u_bridge (
		.clk(clk), .n_reset(n_reset), .adr(adr), .i_data(i_data),
		.o_data(o_data), .is_output(is_output), .n_sltsl(n_sltsl), .n_rd(n_rd),
		.n_wr(n_wr), .n_ioreq(n_ioreq), .bus_address(bus_address),
		.bus_read_data(bus_read_data), .bus_read_data_en(bus_read_data_en),
		.bus_write_data(bus_write_data), .bus_io_req(bus_io_req),
		.bus_memory_req(bus_memory_req), .bus_ack(bus_ack), .bus_write(bus_write)
	);

	access_decoder u_decoder (
		.clk(clk), .n_reset(n_reset), .bus_address(bus_address),
		.bus_io_req(bus_io_req), .bus_memory_req(bus_memory_req),
		.bus_write(bus_write), .access_start(access_start), .target(target),
		.reg_sel(reg_sel), .ram_we(ram_we), .reg_we(reg_we)
	);

	// ----------------------------------------------------------
	// execute and response
	// ----------------------------------------------------------

	// ram offset is the low address byte inside the window
	cart_ram u_ram (
		.clk(clk), .offset(bus_address[7:0]), .page(page), .we(ram_we),
		.wdata(bus_write_data), .rdata(ram_rdata)
	);

	io_register_bank u_regs (
		.clk(clk), .n_reset(n_reset), .reg_sel(reg_sel), .we(reg_we),
		.wdata(bus_write_data), .rdata(reg_rdata), .page(page)
	);

	response_mux u_resp (
		.clk(clk), .n_reset(n_reset), .access_start(access_start), .target(target),
		.bus_write(bus_write), .ram_rdata(ram_rdata), .reg_rdata(reg_rdata),
		.bus_ack(bus_ack), .bus_read_data(bus_read_data),
		.bus_read_data_en(bus_read_data_en)
	);

endmodule

`default_nettype wire

// File: verif/tb_msx_cart.sv
`default_nettype none

module tb_msx_cart;

	timeunit 1ns;
	timeprecision 1ps;

	// roughly 180 bus cycles of 11 clocks fit twice into this limit
	localparam int          TIMEOUT_CYCLES = 5000;
	localparam logic [31:0] SEED           = 32'ha90d_06d1;

	logic        clk = 1'b0;
	logic        n_reset;
	logic [15:0] adr;
	logic [7:0]  i_data;
	logic [7:0]  o_data;
	logic        is_output;
	logic        n_sltsl;
	logic        n_rd;
	logic        n_wr;
	logic        n_ioreq;

	// reference model of the cartridge state
	logic [7:0]  ram_model [0:1023];
	logic [1:0]  page_model;
	logic [7:0]  scratch_model;
	// expectation for the read strobe in progress
	logic [7:0]  exp_o_data;
	logic        exp_claimed;

	logic [31:0] rng_state;
	logic [7:0]  offsets [0:31];
	logic [7:0]  page_offsets [0:7];
	int          error_count;
	int          test_errors;
	int          pass_count;
	int          fail_count;
	int          cycle_count;

	msx_cart_top UUT (
		.clk(clk), .n_reset(n_reset), .adr(adr), .i_data(i_data), .o_data(o_data),
		.is_output(is_output), .n_sltsl(n_sltsl), .n_rd(n_rd), .n_wr(n_wr),
		.n_ioreq(n_ioreq)
	);

	// ----------------------------------------------------------
	// clock and run limit
	// ----------------------------------------------------------

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ----------------------------------------------------------
	// checking
	// ----------------------------------------------------------

	// driven read data must follow the model
	o_data_matches: assert property (@(posedge clk) disable iff (!n_reset)
		is_output |-> (o_data == exp_o_data))
	else begin
		error_count = error_count + 1;
		$display("MISMATCH o_data expected %02h actual %02h at adr %04h",
			$sampled(exp_o_data), $sampled(o_data), $sampled(adr));
	end

	// buffer never drives outside a read strobe
	output_only_in_read: assert property (@(posedge clk) disable iff (!n_reset)
		n_rd |-> !is_output)
	else begin
		error_count = error_count + 1;
		$display("is_output is high while n_rd is high");
	end

	// a claimed read must have driven data before its strobe ended
	claimed_read_drives: assert property (@(posedge clk) disable iff (!n_reset)
		($rose(n_rd) && exp_claimed) |-> $past(is_output))
	else begin
		error_count = error_count + 1;
		$display("is_output never went high during a claimed read at adr %04h",
			$sampled(adr));
	end

	// unclaimed reads leave the slot data bus alone
	unclaimed_read_quiet: assert property (@(posedge clk) disable iff (!n_reset)
		(!n_rd && !exp_claimed) |-> !is_output)
	else begin
		error_count = error_count + 1;
		$display("is_output went high during an unclaimed read at adr %04h",
			$sampled(adr));
	end

	// ----------------------------------------------------------
	// random numbers
	// ----------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// ----------------------------------------------------------
	// bus cycles entered and left on a falling edge
	// ----------------------------------------------------------

	task automatic bus_cycle(input logic [15:0] address, input logic [7:0] data,
			input logic io, input logic write);
		adr     = address;
		i_data  = data;
		n_ioreq = ~io;
		n_sltsl = io;
		if (write) begin
			n_wr = 1'b0;
		end else begin
			n_rd = 1'b0;
		end
		repeat (8) @(negedge clk);
		n_rd    = 1'b1;
		n_wr    = 1'b1;
		n_ioreq = 1'b1;
		n_sltsl = 1'b1;
		repeat (3) @(negedge clk);
	endtask

	// window is adr[15:14] == 01 and the offset is the low byte
	task automatic mem_write(input logic [15:0] address, input logic [7:0] data);
		if (address[15:14] == 2'b01) begin
			ram_model[{page_model, address[7:0]}] = data;
		end
		exp_claimed = 1'b0;
		bus_cycle(address, data, 1'b0, 1'b1);
	endtask

	task automatic mem_read(input logic [15:0] address);
		exp_claimed = (address[15:14] == 2'b01);
		exp_o_data  = exp_claimed ? ram_model[{page_model, address[7:0]}] : 8'h00;
		bus_cycle(address, 8'h00, 1'b0, 1'b0);
	endtask

	// ports 0x40 page, 0x41 scratch, 0x42 id which ignores writes
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		case (port)
			8'h40:   page_model = data[1:0];
			8'h41:   scratch_model = data;
			default: ;
		endcase
		exp_claimed = 1'b0;
		bus_cycle({8'h00, port}, data, 1'b1, 1'b1);
	endtask

	task automatic io_read(input logic [7:0] port);
		exp_claimed = 1'b1;
		case (port)
			8'h40:   exp_o_data = {6'd0, page_model};
			8'h41:   exp_o_data = scratch_model;
			8'h42:   exp_o_data = 8'hA5;
			default: begin
				exp_claimed = 1'b0;
				exp_o_data  = 8'h00;
			end
		endcase
		bus_cycle({8'h00, port}, 8'h00, 1'b1, 1'b0);
	endtask

	// ----------------------------------------------------------
	// tests
	// ----------------------------------------------------------

	task automatic report_test(input string name);
		if (error_count == test_errors) begin
			pass_count = pass_count + 1;
			$display("test %-16s ok", name);
		end else begin
			fail_count = fail_count + 1;
			$display("test %-16s failed, %0d errors", name, error_count - test_errors);
		end
		test_errors = error_count;
	endtask

	task automatic reset_defaults();
		reset_output_low: assert (!is_output) else begin
			error_count = error_count + 1;
			$display("is_output is high right after reset");
		end
		io_read(8'h40);
		io_read(8'h41);
		report_test("reset defaults");
	endtask

	// upper window bits are random since only the low byte selects the cell
	task automatic ram_round_trip();
		logic [31:0] r;
		for (int i = 0; i < 32; i++) begin
			r          = next_random();
			offsets[i] = r[7:0];
			mem_write({2'b01, r[13:8], r[7:0]}, r[23:16]);
		end
		for (int i = 0; i < 32; i++) begin
			r = next_random();
			mem_read({2'b01, r[13:8], offsets[i]});
		end
		report_test("ram round trip");
	endtask

	// same offsets in every page must hold separate bytes
	task automatic page_switching();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r               = next_random();
			page_offsets[i] = r[7:0];
		end
		for (int p = 0; p < 4; p++) begin
			io_write(8'h40, 8'(p));
			for (int i = 0; i < 8; i++) begin
				r = next_random();
				mem_write({2'b01, r[13:8], page_offsets[i]}, r[23:16]);
			end
		end
		for (int p = 3; p >= 0; p--) begin
			io_write(8'h40, 8'(p));
			io_read(8'h40);
			for (int i = 0; i < 8; i++) begin
				mem_read({8'h40, page_offsets[i]});
			end
		end
		// only two page bits survive
		io_write(8'h40, 8'hff);
		io_read(8'h40);
		io_write(8'h40, 8'h00);
		io_read(8'h40);
		report_test("paging");
	endtask

	task automatic scratch_and_id();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			io_write(8'h41, r[7:0]);
			io_read(8'h41);
		end
		io_read(8'h42);
		r = next_random();
		io_write(8'h42, r[7:0]);
		io_read(8'h42);
		io_read(8'h40);
		report_test("scratch and id");
	endtask

	// writes here would corrupt page, scratch or ram if wrongly claimed
	task automatic unclaimed_access();
		logic [31:0] r;
		mem_read(16'h8000);
		io_read(8'h50);
		mem_write({8'h80, page_offsets[0]}, ~ram_model[{page_model, page_offsets[0]}]);
		mem_write({8'hc0, page_offsets[1]}, ~ram_model[{page_model, page_offsets[1]}]);
		r = next_random();
		io_write(8'h50, 8'h02);
		io_write(8'h51, r[7:0]);
		io_read(8'h40);
		io_read(8'h41);
		for (int i = 0; i < 4; i++) begin
			mem_read({8'h40, page_offsets[i]});
		end
		report_test("unclaimed");
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------

	initial begin
		n_reset       = 1'b0;
		adr           = 16'h0000;
		i_data        = 8'h00;
		n_sltsl       = 1'b1;
		n_rd          = 1'b1;
		n_wr          = 1'b1;
		n_ioreq       = 1'b1;
		page_model    = 2'd0;
		scratch_model = 8'h00;
		exp_o_data    = 8'h00;
		exp_claimed   = 1'b0;
		rng_state     = SEED;
		error_count   = 0;
		test_errors   = 0;
		pass_count    = 0;
		fail_count    = 0;
		cycle_count   = 0;
		repeat (3) @(negedge clk);
		n_reset = 1'b1;
		@(negedge clk);
		reset_defaults();
		ram_round_trip();
		page_switching();
		scratch_and_id();
		unclaimed_access();
		$display("tests passed %0d, tests failed %0d, errors %0d",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/msx_cart_pkg.sv
source/msx_bus_bridge.sv
source/access_decoder.sv
source/cart_ram.sv
source/io_register_bank.sv
source/response_mux.sv
source/msx_cart_top.sv
verif/tb_msx_cart.sv

// File: Bender.yml
package:
  name: msx_cart

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/msx_cart_pkg.sv
      - source/msx_bus_bridge.sv
      - source/access_decoder.sv
      - source/cart_ram.sv
      - source/io_register_bank.sv
      - source/response_mux.sv
      - source/msx_cart_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verif/tb_msx_cart.sv
